/* verilog/alu_consts.svh */
// Width and depth macros for the board ALU: data, opcode, switch bank, synchronizer
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Operand and result width, one word
`define ALU_DATA_W 5

// Raw operation code width, MIPS function field
`define ALU_OP_W 6

// Switch bank: operand A, operand B, then opcode from the LSB up
`define ALU_SW_W ((2 * `ALU_DATA_W) + `ALU_OP_W)

// Button synchronizer depth
`define ALU_SYNC_STAGES 2

`endif

/* verilog/alu_pkg.sv */
// Package alu_pkg with the decoded operation enum and the raw MIPS function codes
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

    // Decoded operation, OP_NONE for anything not in the table
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SRL,
        OP_SRA,
        OP_NONE
    } alu_op_e;

    parameter logic [`ALU_OP_W-1:0] FUNCT_ADD = 6'b100000;
    parameter logic [`ALU_OP_W-1:0] FUNCT_SUB = 6'b100010;
    parameter logic [`ALU_OP_W-1:0] FUNCT_AND = 6'b100100;
    parameter logic [`ALU_OP_W-1:0] FUNCT_OR  = 6'b100101;
    parameter logic [`ALU_OP_W-1:0] FUNCT_XOR = 6'b100110;
    parameter logic [`ALU_OP_W-1:0] FUNCT_NOR = 6'b100111;
    parameter logic [`ALU_OP_W-1:0] FUNCT_SRL = 6'b000010; // Logical right shift
    parameter logic [`ALU_OP_W-1:0] FUNCT_SRA = 6'b000011; // Arithmetic right shift

endpackage

`default_nettype wire

/* verilog/button_capture.sv */
// Module button_capture: button synchronizer, rising edge strobe and payload latch
`default_nettype none
`timescale 1ns/10ps

`include "alu_consts.svh"

module button_capture #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     i_clock,
    input  logic     i_arst_n,
    input  logic     i_button,      // Raw push-button level
    input  T_PAYLOAD i_value,       // Field to latch
    output T_PAYLOAD o_value,
    output logic     o_captured     // One cycle, after o_value updates
);

    logic [`ALU_SYNC_STAGES-1:0] sync_q;
    logic                        btn_q;     // Last synchronized level
    logic                        rise_q;    // Registered edge strobe
    logic                        captured_q;
    logic                        btn_sync;

    assign btn_sync = sync_q[`ALU_SYNC_STAGES-1];

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_q <= '0;
            btn_q  <= 1'b0;
            rise_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[`ALU_SYNC_STAGES-2:0], i_button};
            btn_q  <= btn_sync;
            rise_q <= btn_sync & ~btn_q;    // Held button gives one strobe only
        end
    end

    // Field latch on the strobe
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_value    <= '0;
            captured_q <= 1'b0;
        end else begin
            captured_q <= rise_q;
            if (rise_q) begin
                o_value <= i_value;
            end
        end
    end

    assign o_captured = captured_q;

endmodule

`default_nettype wire

/* verilog/alu_input_decode.sv */
// Module alu_input_decode: switch field split, three button captures, opcode decode, load pulse
`default_nettype none
`timescale 1ns/10ps

`include "alu_consts.svh"

module alu_input_decode
    import alu_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  logic [`ALU_SW_W-1:0]   i_switches,
    input  logic                   i_button_a,
    input  logic                   i_button_b,
    input  logic                   i_button_op,
    output logic [`ALU_DATA_W-1:0] o_alu_a,
    output logic [`ALU_DATA_W-1:0] o_alu_b,
    output alu_op_e                o_alu_op,
    output logic                   o_load       // One cycle after any capture
);

    logic [`ALU_DATA_W-1:0] sw_a;
    logic [`ALU_DATA_W-1:0] sw_b;
    logic [`ALU_OP_W-1:0]   sw_op;
    logic [`ALU_OP_W-1:0]   raw_op;     // Latched function code
    logic                   cap_a;
    logic                   cap_b;
    logic                   cap_op;
    logic                   load_q;

    // Field slicing, A in the low bits
    assign sw_a  = i_switches[`ALU_DATA_W-1:0];
    assign sw_b  = i_switches[(2 * `ALU_DATA_W)-1:`ALU_DATA_W];
    assign sw_op = i_switches[`ALU_SW_W-1:(2 * `ALU_DATA_W)];

    button_capture #(.T_PAYLOAD(logic [`ALU_DATA_W-1:0])) u_cap_a (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_button   (i_button_a),
        .i_value    (sw_a),
        .o_value    (o_alu_a),
        .o_captured (cap_a)
    );

    button_capture #(.T_PAYLOAD(logic [`ALU_DATA_W-1:0])) u_cap_b (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_button   (i_button_b),
        .i_value    (sw_b),
        .o_value    (o_alu_b),
        .o_captured (cap_b)
    );

    button_capture #(.T_PAYLOAD(logic [`ALU_OP_W-1:0])) u_cap_op (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_button   (i_button_op),
        .i_value    (sw_op),
        .o_value    (raw_op),
        .o_captured (cap_op)
    );

    // MIPS function field to enum
    always_comb begin
        case (raw_op)
            FUNCT_ADD: o_alu_op = OP_ADD;
            FUNCT_SUB: o_alu_op = OP_SUB;
            FUNCT_AND: o_alu_op = OP_AND;
            FUNCT_OR:  o_alu_op = OP_OR;
            FUNCT_XOR: o_alu_op = OP_XOR;
            FUNCT_NOR: o_alu_op = OP_NOR;
            FUNCT_SRL: o_alu_op = OP_SRL;
            FUNCT_SRA: o_alu_op = OP_SRA;
            default:   o_alu_op = OP_NONE;  // Illegal code, result zero
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= cap_a | cap_b | cap_op;
        end
    end

    assign o_load = load_q;

endmodule

`default_nettype wire

/* verilog/alu_execute.sv */
// Module alu_execute: combinational ALU with registered result, overflow and zero flags
`default_nettype none
`timescale 1ns/10ps

`include "alu_consts.svh"

module alu_execute
    import alu_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  logic [`ALU_DATA_W-1:0] i_alu_a,
    input  logic [`ALU_DATA_W-1:0] i_alu_b,
    input  alu_op_e                i_alu_op,
    input  logic                   i_load,
    output logic [`ALU_DATA_W-1:0] o_result,
    output logic                   o_overflow_flag,
    output logic                   o_zero_flag
);

    localparam int MSB = `ALU_DATA_W - 1;

    logic [`ALU_DATA_W-1:0] sum_c;
    logic [`ALU_DATA_W-1:0] diff_c;
    logic [2:0]             shamt;      // Low three bits of B
    logic [`ALU_DATA_W-1:0] result_c;
    logic                   overflow_c;
    logic [`ALU_DATA_W-1:0] result_q;
    logic                   overflow_q;
    logic                   zero_q;

    assign sum_c  = i_alu_a + i_alu_b;
    assign diff_c = i_alu_a - i_alu_b;
    assign shamt  = i_alu_b[2:0];

    always_comb begin
        result_c   = '0;
        overflow_c = 1'b0;
        case (i_alu_op)
            OP_ADD: begin
                result_c = sum_c;
                // Same-sign operands, sign flipped
                overflow_c = (i_alu_a[MSB] == i_alu_b[MSB]) && (sum_c[MSB] != i_alu_a[MSB]);
            end
            OP_SUB: begin
                result_c   = diff_c;
                overflow_c = (i_alu_a[MSB] != i_alu_b[MSB]) && (diff_c[MSB] != i_alu_a[MSB]);
            end
            OP_AND: result_c = i_alu_a & i_alu_b;
            OP_OR:  result_c = i_alu_a | i_alu_b;
            OP_XOR: result_c = i_alu_a ^ i_alu_b;
            OP_NOR: result_c = ~(i_alu_a | i_alu_b);
            OP_SRL: result_c = i_alu_a >> shamt;
            OP_SRA: result_c = $unsigned($signed(i_alu_a) >>> shamt);  // Sign fill
            default: begin
                result_c   = '0;
                overflow_c = 1'b0;
            end
        endcase
    end

    // Output register, zero result after reset so zero LED starts high
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            result_q   <= '0;
            overflow_q <= 1'b0;
            zero_q     <= 1'b1;
        end else if (i_load) begin
            result_q   <= result_c;
            overflow_q <= overflow_c;
            zero_q     <= (result_c == '0);
        end
    end

    assign o_result        = result_q;
    assign o_overflow_flag = overflow_q;
    assign o_zero_flag     = zero_q;

endmodule

`default_nettype wire

/* verilog/alu_top.sv */
// Module alu_top: board ALU with input decode and execute stages, switch width check
`default_nettype none
`timescale 1ns/10ps

`include "alu_consts.svh"

module alu_top
    import alu_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  logic [`ALU_SW_W-1:0]   i_switches,      // Board switch bank
    input  logic                   i_button_a,      // Latch operand A
    input  logic                   i_button_b,      // Latch operand B
    input  logic                   i_button_op,     // Latch operation
    output logic [`ALU_DATA_W-1:0] o_led_result,
    output logic                   o_overflow_flag, // Overflow LED
    output logic                   o_zero_flag      // Zero LED
);

    logic [`ALU_DATA_W-1:0] alu_a;
    logic [`ALU_DATA_W-1:0] alu_b;
    alu_op_e                alu_op;
    logic                   load;

    // Board has only 16 switches
    if (`ALU_SW_W > 16) begin : g_sw_check
        $error("Switch field width %0d exceeds the 16 board switches", `ALU_SW_W);
    end

    alu_input_decode u_decode (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_switches  (i_switches),
        .i_button_a  (i_button_a),
        .i_button_b  (i_button_b),
        .i_button_op (i_button_op),
        .o_alu_a     (alu_a),
        .o_alu_b     (alu_b),
        .o_alu_op    (alu_op),
        .o_load      (load)
    );

    // LEDs come straight from the execute registers
    alu_execute u_execute (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_alu_a         (alu_a),
        .i_alu_b         (alu_b),
        .i_alu_op        (alu_op),
        .i_load          (load),
        .o_result        (o_led_result),
        .o_overflow_flag (o_overflow_flag),
        .o_zero_flag     (o_zero_flag)
    );

endmodule

`default_nettype wire

/* tb/alu_top_assert.sv */
// Module alu_top_assert: flag and stability checks on alu_execute, with its bind
`default_nettype none
`timescale 1ns/10ps

`include "alu_consts.svh"

module alu_top_assert
    import alu_pkg::*;
(
    input logic                   i_clock,
    input logic                   i_arst_n,
    input alu_op_e                i_alu_op,
    input logic                   i_load,
    input logic [`ALU_DATA_W-1:0] i_result,
    input logic                   i_overflow_flag,
    input logic                   i_zero_flag
);

    int ovf_errors    = 0;
    int zero_errors   = 0;
    int stable_errors = 0;

    // Only ADD and SUB may set overflow
    a_ovf_arith: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_load && i_alu_op != OP_ADD && i_alu_op != OP_SUB) |=> !i_overflow_flag)
        else begin
            ovf_errors++;
            $error("Overflow flag set by an operation other than ADD or SUB");
        end

    a_zero_flag: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_load |=> (i_zero_flag == (i_result == '0)))
        else begin
            zero_errors++;
            $error("Zero flag does not match the registered result");
        end

    a_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !i_load |=> ($stable(i_result) && $stable(i_overflow_flag) && $stable(i_zero_flag)))
        else begin
            stable_errors++;
            $error("ALU outputs changed without a load pulse");
        end

endmodule

bind alu_execute alu_top_assert u_assert (
    .i_clock         (i_clock),
    .i_arst_n        (i_arst_n),
    .i_alu_op        (i_alu_op),
    .i_load          (i_load),
    .i_result        (o_result),
    .i_overflow_flag (o_overflow_flag),
    .i_zero_flag     (o_zero_flag)
);

`default_nettype wire

/* tb/alu_top_tb.sv */
// Testbench alu_top_tb: stimulus file reader, button presses, reference ALU model and LED checks
`default_nettype none
`timescale 1ns/10ps

`include "alu_consts.svh"

module alu_top_tb
    import alu_pkg::*;
();

    localparam int DW            = `ALU_DATA_W;
    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DLY     = 5;
    localparam int MAX_TESTS     = 32;
    localparam int HOLD_CYCLES   = 4;
    localparam int PRESS_TIMEOUT = 10;
    localparam int QUIET_CYCLES  = 8;   // Watch window for a held button

    logic                 i_clock;
    logic                 i_arst_n;
    logic [`ALU_SW_W-1:0] i_switches;
    logic                 i_button_a;
    logic                 i_button_b;
    logic                 i_button_op;
    logic [DW-1:0]        o_led_result;
    logic                 o_overflow_flag;
    logic                 o_zero_flag;

    logic [15:0]          stim_mem [0:5*MAX_TESTS-1];  // Five words per test
    logic [DW-1:0]        model_a;
    logic [DW-1:0]        model_b;
    logic [`ALU_OP_W-1:0] model_op;
    int                   error_count;

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    alu_top UUT (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_switches      (i_switches),
        .i_button_a      (i_button_a),
        .i_button_b      (i_button_b),
        .i_button_op     (i_button_op),
        .o_led_result    (o_led_result),
        .o_overflow_flag (o_overflow_flag),
        .o_zero_flag     (o_zero_flag)
    );

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic next_drive_point();
        @(posedge i_clock);
        #DRIVE_DLY;
    endtask

    task automatic set_button(input int idx, input logic level);
        case (idx)
            0:       i_button_a  = level;
            1:       i_button_b  = level;
            default: i_button_op = level;
        endcase
    endtask

    task automatic wait_for_load(input int idx);
        int n;
        bit seen;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < PRESS_TIMEOUT) begin
            next_drive_point();
            seen = UUT.load;
            n++;
        end
        if (!seen) begin
            $display("Timeout: no load pulse within %0d cycles of button %0d", PRESS_TIMEOUT, idx);
            error_count++;
        end
    endtask

    task automatic expect_no_load(input int idx);
        int n;
        for (n = 0; n < QUIET_CYCLES; n++) begin
            next_drive_point();
            if (UUT.load) begin
                $display("Button %0d captured again without a new press", idx);
                error_count++;
            end
        end
    endtask

    task automatic press_button(input int idx, input bit hold_check);
        set_button(idx, 1'b1);
        if (hold_check) begin
            wait_for_load(idx);
            i_switches = ~i_switches;   // New field while held, must be ignored
            expect_no_load(idx);
        end else begin
            repeat (HOLD_CYCLES) next_drive_point();
        end
        set_button(idx, 1'b0);
        if (hold_check) begin
            expect_no_load(idx);
        end else begin
            wait_for_load(idx);
        end
    endtask

    // Reference ALU from the MIPS function field rules
    function automatic void alu_model(input logic [DW-1:0] a, input logic [DW-1:0] b,
                                      input logic [`ALU_OP_W-1:0] op,
                                      output logic [DW-1:0] res, output logic ovf);
        int sa;
        int sb;
        int full;
        sa   = int'($signed(a));
        sb   = int'($signed(b));
        full = 0;
        case (op)
            FUNCT_ADD: full = sa + sb;
            FUNCT_SUB: full = sa - sb;
            FUNCT_AND: full = int'(a & b);
            FUNCT_OR:  full = int'(a | b);
            FUNCT_XOR: full = int'(a ^ b);
            FUNCT_NOR: full = int'(~(a | b));
            FUNCT_SRL: full = int'(a) >> b[2:0];    // Zero fill
            FUNCT_SRA: full = sa >>> b[2:0];        // Sign fill
            default:   full = 0;
        endcase
        // True sum outside the signed word range
        ovf = (op == FUNCT_ADD || op == FUNCT_SUB) &&
              (full > (2 ** (DW - 1)) - 1 || full < -(2 ** (DW - 1)));
        res = full[DW-1:0];
    endfunction

    initial begin
        int i;
        int b;
        int num_tests;
        int fail_tests;
        int errors_before;
        int assert_fails;
        logic [15:0] sw;
        logic [15:0] mask;
        logic [DW-1:0] m_res;
        logic m_ovf;
        i_arst_n    = 1'b0;
        i_switches  = '0;
        i_button_a  = 1'b0;
        i_button_b  = 1'b0;
        i_button_op = 1'b0;
        model_a     = '0;
        model_b     = '0;
        model_op    = '0;
        error_count = 0;
        fail_tests  = 0;
        for (i = 0; i < 5 * MAX_TESTS; i++) begin
            stim_mem[i] = 16'hffff;     // Unused entries end the list
        end
        $readmemh("tb/alu_stim.txt", stim_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && stim_mem[5 * num_tests + 1] != 16'hffff) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("No test vectors were read from tb/alu_stim.txt");
            error_count++;
        end

        repeat (10) @(posedge i_clock);
        #DRIVE_DLY;
        i_arst_n = 1'b1;

        for (i = 0; i < num_tests; i++) begin
            sw            = stim_mem[5 * i];
            mask          = stim_mem[5 * i + 1];
            errors_before = error_count;
            i_switches    = sw;
            for (b = 0; b < 3; b++) begin
                if (mask[b]) begin
                    press_button(b, mask[3]);
                end
            end
            if (mask[0]) model_a = sw[DW-1:0];
            if (mask[1]) model_b = sw[2*DW-1:DW];
            if (mask[2]) model_op = sw[`ALU_SW_W-1:2*DW];
            next_drive_point();     // LEDs follow one edge after the load
            alu_model(model_a, model_b, model_op, m_res, m_ovf);
            check_value("stim_result", stim_mem[5 * i + 2], 16'(m_res));
            check_value("stim_overflow", stim_mem[5 * i + 3], 16'(m_ovf));
            check_value("stim_zero", stim_mem[5 * i + 4], 16'(m_res == '0));
            check_value("o_led_result", 16'(o_led_result), 16'(m_res));
            check_value("o_overflow_flag", 16'(o_overflow_flag), 16'(m_ovf));
            check_value("o_zero_flag", 16'(o_zero_flag), 16'(m_res == '0));
            if (error_count != errors_before) fail_tests++;
            $display("Test %0d: switches 0x%4h buttons 0x%0h %s", i, sw, mask,
                     (error_count == errors_before) ? "ok" : "failed");
        end

        assert_fails = UUT.u_execute.u_assert.ovf_errors +
                       UUT.u_execute.u_assert.zero_errors +
                       UUT.u_execute.u_assert.stable_errors;
        check_value("assertion_failures", 16'(assert_fails), 16'h0000);
        $display("Tests: %0d run, %0d failed, %0d errors", num_tests, fail_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/alu_stim.txt */
// switches  buttons(bit0 A, bit1 B, bit2 Op, bit3 hold check)  result  overflow  zero
// switches = {op[5:0], b[4:0], a[4:0]}, all values hex
0000 0 00 0 1
802F 7 10 1 0
8083 7 07 0 0
8210 7 00 1 1
8830 7 0F 1 0
88A5 7 00 0 1
88E3 7 1C 0 0
91DB 7 0A 0 0
95DB 4 1F 0 0
99DB 4 15 0 0
9DDB 4 00 0 1
0878 7 03 0 0
0C78 4 1F 0 0
0D54 7 1D 0 0
0954 4 05 0 0
FD54 4 00 0 1
8154 4 1E 0 0
007F 2 17 0 0
00A0 A 19 0 0
FF5F 2 0E 1 0

/* alu_top.f */
+incdir+verilog
verilog/alu_pkg.sv
verilog/button_capture.sv
verilog/alu_input_decode.sv
verilog/alu_execute.sv
verilog/alu_top.sv
tb/alu_top_assert.sv
tb/alu_top_tb.sv

/* Makefile */
# Verilator build and run for the board ALU testbench

VERILATOR ?= verilator
TOP       ?= alu_top_tb
FILELIST  ?= alu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Status comes from the pass line in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
